/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module exec_stage_tb -f exec_stage.f
	./obj_dir/Vexec_stage_tb

clean:
	rm -rf obj_dir

/* exec_alu.sv */
// Integer ALU, one slot
// Registers the result on start and holds it until the completion grant
`default_nettype none

module exec_alu (
    input  logic                clock,
    input  logic                reset,
    input  logic                start,
    input  exec_pkg::alu_func_t func,
    input  exec_pkg::xlen_t     opa,
    input  exec_pkg::xlen_t     opb,
    input  exec_pkg::tag_t      tag,
    input  logic                grant,
    output logic                done,
    output exec_pkg::xlen_t     result,
    output exec_pkg::tag_t      done_tag
);
    import exec_pkg::*;

    xlen_t                  alu_out;
    logic [SHAMT_WIDTH-1:0] shamt;

    assign shamt = opb[SHAMT_WIDTH-1:0];  // Low bits only

    always_comb begin
        case (func)
            ALU_ADD:  alu_out = opa + opb;
            ALU_SUB:  alu_out = opa - opb;
            ALU_AND:  alu_out = opa & opb;
            ALU_OR:   alu_out = opa | opb;
            ALU_XOR:  alu_out = opa ^ opb;
            ALU_SLT:  alu_out = {{(XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
            ALU_SLTU: alu_out = {{(XLEN-1){1'b0}}, opa < opb};
            ALU_SLL:  alu_out = opa << shamt;
            ALU_SRL:  alu_out = opa >> shamt;
            ALU_SRA:  alu_out = xlen_t'($signed(opa) >>> shamt);
            default:  alu_out = '0;  // Multiply codes go to the multiplier
        endcase
    end

    // A new start wins over a grant on the same edge
    always_ff @(posedge clock) begin
        if (reset) begin
            done <= 1'b0;
        end else if (start) begin
            done <= 1'b1;
        end else if (grant) begin
            done <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            result   <= alu_out;
            done_tag <= tag;
        end
    end

endmodule

`default_nettype wire

/* exec_branch_unit.sv */
// Branch unit, one slot
// Resolves the branch condition and target, holds them until granted
`default_nettype none

module exec_branch_unit (
    input  logic             clock,
    input  logic             reset,
    input  logic             start,
    input  exec_pkg::inst_t  inst,
    input  exec_pkg::xlen_t  opa,
    input  exec_pkg::xlen_t  opb,
    input  exec_pkg::xlen_t  rs1_value,
    input  exec_pkg::xlen_t  rs2_value,
    input  exec_pkg::tag_t   tag,
    input  logic             grant,
    output logic             done,
    output exec_pkg::xlen_t  target,
    output logic             take,
    output exec_pkg::tag_t   done_tag
);
    import exec_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_jalr;
    logic       cond_take;
    xlen_t      sum;

    assign opcode  = inst[OPCODE_MSB:OPCODE_LSB];
    assign funct3  = inst[FUNCT3_MSB:FUNCT3_LSB];
    assign is_jalr = (opcode == OPCODE_JALR);
    assign sum     = opa + opb;

    always_comb begin
        case (funct3)
            F3_BEQ:  cond_take = (rs1_value == rs2_value);
            F3_BNE:  cond_take = (rs1_value != rs2_value);
            F3_BLT:  cond_take = ($signed(rs1_value) < $signed(rs2_value));
            F3_BGE:  cond_take = ($signed(rs1_value) >= $signed(rs2_value));
            F3_BLTU: cond_take = (rs1_value < rs2_value);
            F3_BGEU: cond_take = (rs1_value >= rs2_value);
            default: cond_take = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            done <= 1'b0;
        end else if (start) begin
            done <= 1'b1;
        end else if (grant) begin
            done <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            target   <= {sum[XLEN-1:1], sum[0] & ~is_jalr};  // JALR clears bit 0
            take     <= (opcode == OPCODE_JAL) || is_jalr || cond_take;
            done_tag <= tag;
        end
    end

endmodule

`default_nettype wire

/* exec_clock_gen.sv */
// Testbench clock and reset generator
// 8 ns clock, synchronous reset held for the first cycles
`default_nettype none

module exec_clock_gen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 10
) (
    output logic clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD) clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;  // Released just after an edge
    end

endmodule

`default_nettype wire

/* exec_complete_arbiter.sv */
// Completion bus arbiter
// Fixed priority ALU, MULT, BRANCH, gated by downstream completion credits
`default_nettype none

module exec_complete_arbiter #(
    parameter int COMPLETE_CREDITS = 2
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               alu_done,
    input  logic               mult_done,
    input  logic               branch_done,
    input  exec_pkg::xlen_t    alu_result,
    input  exec_pkg::xlen_t    mult_result,
    input  exec_pkg::xlen_t    branch_target,
    input  exec_pkg::tag_t     alu_tag,
    input  exec_pkg::tag_t     mult_tag,
    input  exec_pkg::tag_t     branch_tag,
    input  logic               branch_take,
    input  logic               complete_credit,
    output exec_pkg::fu_vec_t  grant,
    output logic               complete_valid,
    output exec_pkg::fu_kind_t complete_fu,
    output exec_pkg::tag_t     complete_tag,
    output exec_pkg::xlen_t    complete_result,
    output logic               complete_take
);
    import exec_pkg::*;

    localparam int CREDIT_WIDTH = $clog2(COMPLETE_CREDITS + 1);

    logic [CREDIT_WIDTH-1:0] credits;
    logic                    granted;
    fu_kind_t                win_fu;
    tag_t                    win_tag;
    xlen_t                   win_result;
    logic                    win_take;

    always_comb begin
        grant = '0;
        if (credits != '0) begin
            if (alu_done)         grant[FU_ALU]    = 1'b1;
            else if (mult_done)   grant[FU_MULT]   = 1'b1;
            else if (branch_done) grant[FU_BRANCH] = 1'b1;
        end
    end

    assign granted = |grant;

    // Winner payload defaults to the ALU
    always_comb begin
        win_fu     = FU_ALU;
        win_tag    = alu_tag;
        win_result = alu_result;
        win_take   = 1'b0;
        if (grant[FU_MULT]) begin
            win_fu     = FU_MULT;
            win_tag    = mult_tag;
            win_result = mult_result;
        end else if (grant[FU_BRANCH]) begin
            win_fu     = FU_BRANCH;
            win_tag    = branch_tag;
            win_result = branch_target;
            win_take   = branch_take;
        end
    end

    // Credit spent on the grant edge and returned one per pulse
    always_ff @(posedge clock) begin
        if (reset) begin
            credits        <= CREDIT_WIDTH'(COMPLETE_CREDITS);
            complete_valid <= 1'b0;
        end else begin
            credits        <= credits + CREDIT_WIDTH'(complete_credit) - CREDIT_WIDTH'(granted);
            complete_valid <= granted;
        end
    end

    always_ff @(posedge clock) begin
        if (granted) begin
            complete_fu     <= win_fu;
            complete_tag    <= win_tag;
            complete_result <= win_result;
            complete_take   <= win_take;
        end
    end

endmodule

`default_nettype wire

/* exec_multiplier.sv */
// Sequential multiplier for MUL, MULH, MULHSU and MULHU
// Retires BITS_PER_CYCLE multiplier bits per cycle, holds the product until granted
`default_nettype none

module exec_multiplier #(
    parameter int BITS_PER_CYCLE = 8
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                start,
    input  exec_pkg::alu_func_t func,
    input  exec_pkg::xlen_t     opa,
    input  exec_pkg::xlen_t     opb,
    input  exec_pkg::tag_t      tag,
    input  logic                grant,
    output logic                done,
    output exec_pkg::xlen_t     product,
    output exec_pkg::tag_t      done_tag
);
    import exec_pkg::*;

    localparam int STEPS       = XLEN / BITS_PER_CYCLE;
    localparam int COUNT_WIDTH = $clog2(STEPS + 1);

    typedef logic [2*XLEN-1:0] wide_t;
    typedef enum logic [1:0] {IDLE, RUN, HOLD} mult_state_t;

    mult_state_t            state;
    logic [COUNT_WIDTH-1:0] count;
    logic                   last_step;
    logic                   opa_signed;
    logic                   opb_signed;
    logic                   high_word;   // MULH* return the upper word
    wide_t                  mcand;
    wide_t                  mplier;
    wide_t                  acc;
    wide_t                  partial;
    wide_t                  corrected;

    assign opa_signed = (func == ALU_MUL) || (func == ALU_MULH) || (func == ALU_MULHSU);
    assign opb_signed = (func == ALU_MUL) || (func == ALU_MULH);
    assign last_step  = (count == COUNT_WIDTH'(STEPS));
    assign partial    = mcand * wide_t'(mplier[BITS_PER_CYCLE-1:0]);

    // After STEPS shifts the rest of mplier is all sign bits, worth -2^XLEN,
    // and mcand already carries the 2^XLEN weight
    assign corrected = mplier[0] ? acc - mcand : acc;

    ////////////////////
    // Control

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
            count <= '0;
            done  <= 1'b0;
        end else if (start) begin
            state <= RUN;
            count <= '0;
            done  <= 1'b0;
        end else begin
            case (state)
                RUN: begin
                    if (last_step) begin
                        state <= HOLD;
                        done  <= 1'b1;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                HOLD: begin
                    if (grant) begin
                        state <= IDLE;
                        done  <= 1'b0;
                    end
                end
                default: ;
            endcase
        end
    end

    ////////////////////
    // Datapath

    always_ff @(posedge clock) begin
        if (start) begin
            mcand     <= {{XLEN{opa_signed & opa[XLEN-1]}}, opa};
            mplier    <= {{XLEN{opb_signed & opb[XLEN-1]}}, opb};
            acc       <= '0;
            high_word <= (func != ALU_MUL);
            done_tag  <= tag;
        end else if (state == RUN) begin
            if (last_step) begin
                product <= high_word ? corrected[2*XLEN-1:XLEN] : corrected[XLEN-1:0];
            end else begin
                acc    <= acc + partial;
                mcand  <= mcand << BITS_PER_CYCLE;
                mplier <= mplier >> BITS_PER_CYCLE;
            end
        end
    end

endmodule

`default_nettype wire

/* exec_operand_select.sv */
// Operand select for the execute stage
// Decodes the RISC-V immediates and muxes operands A and B
`default_nettype none

module exec_operand_select (
    input  exec_pkg::opa_sel_t opa_select,
    input  exec_pkg::opb_sel_t opb_select,
    input  exec_pkg::inst_t    inst,
    input  exec_pkg::xlen_t    pc,
    input  exec_pkg::xlen_t    rs1_value,
    input  exec_pkg::xlen_t    rs2_value,
    output exec_pkg::xlen_t    opa,
    output exec_pkg::xlen_t    opb
);
    import exec_pkg::*;

    xlen_t i_imm;
    xlen_t s_imm;
    xlen_t b_imm;
    xlen_t u_imm;
    xlen_t j_imm;

    // Sign-extended immediates, all keyed off inst[31]
    assign i_imm = {{20{inst[31]}}, inst[31:20]};
    assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign b_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign u_imm = {inst[31:12], 12'b0};
    assign j_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (opa_select)
            RS1:     opa = rs1_value;
            NPC:     opa = pc + xlen_t'(4);   // Next sequential PC
            PC:      opa = pc;
            default: opa = '0;
        endcase
    end

    always_comb begin
        case (opb_select)
            RS2:     opb = rs2_value;
            I_IMM:   opb = i_imm;
            S_IMM:   opb = s_imm;
            B_IMM:   opb = b_imm;
            U_IMM:   opb = u_imm;
            J_IMM:   opb = j_imm;
            default: opb = '0;  // Codes 6 and 7
        endcase
    end

endmodule

`default_nettype wire

/* exec_pkg.sv */
// Execute stage shared definitions
// Widths, vector types, unit and function encodings, RISC-V field positions
`default_nettype none

package exec_pkg;

    ////////////////////
    // Widths and vectors

    localparam int XLEN        = 32;
    localparam int TAG_WIDTH   = 5;    // ROB index
    localparam int SHAMT_WIDTH = 5;

    typedef logic [XLEN-1:0]      xlen_t;
    typedef logic [31:0]          inst_t;
    typedef logic [TAG_WIDTH-1:0] tag_t;

    ////////////////////
    // Unit and function encodings

    // Also the bit index into fu_vec_t
    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,
        FU_MULT   = 2'd1,
        FU_BRANCH = 2'd2
    } fu_kind_t;

    typedef logic [2:0] fu_vec_t;  // One bit per unit kind

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU
    } alu_func_t;

    typedef enum logic [1:0] {
        RS1, NPC, PC, ZERO
    } opa_sel_t;

    typedef enum logic [2:0] {
        RS2, I_IMM, S_IMM, B_IMM, U_IMM, J_IMM
    } opb_sel_t;

    ////////////////////
    // RISC-V fields

    localparam int OPCODE_MSB = 6;
    localparam int OPCODE_LSB = 0;
    localparam int FUNCT3_MSB = 14;
    localparam int FUNCT3_LSB = 12;

    localparam logic [6:0] OPCODE_JAL  = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR = 7'b1100111;

    // Conditional branch funct3 codes
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

endpackage

`default_nettype wire

/* exec_stage.f */
exec_pkg.sv
exec_operand_select.sv
exec_alu.sv
exec_branch_unit.sv
exec_multiplier.sv
exec_complete_arbiter.sv
exec_stage.sv
exec_clock_gen.sv
exec_stage_asserts.sv
exec_stage_tb.sv

/* exec_stage.sv */
// Execute stage top level
// Operand select, ALU, branch unit and multiplier sharing one completion bus
`default_nettype none

module exec_stage #(
    parameter int BITS_PER_CYCLE   = 8,
    parameter int COMPLETE_CREDITS = 2
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                issue_valid,
    input  exec_pkg::fu_kind_t  issue_fu,
    input  exec_pkg::alu_func_t issue_func,
    input  exec_pkg::opa_sel_t  opa_select,
    input  exec_pkg::opb_sel_t  opb_select,
    input  exec_pkg::inst_t     inst,
    input  exec_pkg::xlen_t     pc,
    input  exec_pkg::xlen_t     rs1_value,
    input  exec_pkg::xlen_t     rs2_value,
    input  exec_pkg::tag_t      issue_tag,
    input  logic                complete_credit,
    output exec_pkg::fu_vec_t   fu_free,
    output logic                complete_valid,
    output exec_pkg::fu_kind_t  complete_fu,
    output exec_pkg::tag_t      complete_tag,
    output exec_pkg::xlen_t     complete_result,
    output logic                complete_take
);
    import exec_pkg::*;

    xlen_t opa, opb;
    logic  alu_start, mult_start, branch_start;
    logic  alu_done, mult_done, branch_done;
    xlen_t alu_result, mult_result, branch_target;
    tag_t  alu_tag, mult_tag, branch_tag;
    logic  branch_take;

    assign alu_start    = issue_valid && (issue_fu == FU_ALU);
    assign mult_start   = issue_valid && (issue_fu == FU_MULT);
    assign branch_start = issue_valid && (issue_fu == FU_BRANCH);

    exec_operand_select u_operand_select (
        .opa_select, .opb_select, .inst, .pc, .rs1_value, .rs2_value, .opa, .opb
    );

    exec_alu u_alu (
        .clock, .reset, .start(alu_start), .func(issue_func), .opa, .opb,
        .tag(issue_tag), .grant(fu_free[FU_ALU]),
        .done(alu_done), .result(alu_result), .done_tag(alu_tag)
    );

    exec_branch_unit u_branch_unit (
        .clock, .reset, .start(branch_start), .inst, .opa, .opb, .rs1_value, .rs2_value,
        .tag(issue_tag), .grant(fu_free[FU_BRANCH]),
        .done(branch_done), .target(branch_target), .take(branch_take), .done_tag(branch_tag)
    );

    exec_multiplier #(.BITS_PER_CYCLE(BITS_PER_CYCLE)) u_multiplier (
        .clock, .reset, .start(mult_start), .func(issue_func), .opa, .opb,
        .tag(issue_tag), .grant(fu_free[FU_MULT]),
        .done(mult_done), .product(mult_result), .done_tag(mult_tag)
    );

    // Grant doubles as the issue credit return
    exec_complete_arbiter #(.COMPLETE_CREDITS(COMPLETE_CREDITS)) u_complete_arbiter (
        .clock, .reset, .alu_done, .mult_done, .branch_done,
        .alu_result, .mult_result, .branch_target, .alu_tag, .mult_tag, .branch_tag,
        .branch_take, .complete_credit, .grant(fu_free),
        .complete_valid, .complete_fu, .complete_tag, .complete_result, .complete_take
    );

endmodule

`default_nettype wire

/* exec_stage_asserts.sv */
// Execute stage protocol checks
// Issue credits, completion credits and the shape of the free pulses
`default_nettype none

module exec_stage_asserts #(
    parameter int COMPLETE_CREDITS = 2
) (
    input logic               clock,
    input logic               reset,
    input logic               issue_valid,
    input exec_pkg::fu_kind_t issue_fu,
    input exec_pkg::fu_vec_t  fu_free,
    input logic               complete_valid,
    input logic               complete_credit
);
    timeunit 1ns;
    timeprecision 1ps;
    import exec_pkg::*;

    fu_vec_t issue_credit;  // Issuer side view, one credit per unit
    int      bus_credit;    // Completion credits seen from the bus

    always_ff @(posedge clock) begin
        if (reset) begin
            issue_credit <= '1;
            bus_credit   <= COMPLETE_CREDITS;
        end else begin
            for (int k = 0; k < 3; k++) begin
                if (fu_free[k]) begin
                    issue_credit[k] <= 1'b1;
                end else if (issue_valid && int'(issue_fu) == k) begin
                    issue_credit[k] <= 1'b0;
                end
            end
            bus_credit <= bus_credit + int'(complete_credit) - int'(complete_valid);
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        issue_valid |-> issue_credit[issue_fu])
        else $error("Issue to unit %0d without its credit", issue_fu);

    assert property (@(posedge clock) disable iff (reset)
        complete_valid |-> bus_credit > 0)
        else $error("complete_valid with no completion credit left");

    // One cycle wide free pulses
    for (genvar k = 0; k < 3; k++) begin : g_free_pulse
        assert property (@(posedge clock) disable iff (reset)
            fu_free[k] |=> !fu_free[k])
            else $error("fu_free[%0d] high for more than one cycle", k);
    end

endmodule

`default_nettype wire

/* exec_stage_tb.sv */
// Execute stage testbench
// Random issue against a reference model, scoreboarded by tag on the completion bus
`default_nettype none

module exec_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import exec_pkg::*;

    localparam int SEED             = 9650;
    localparam int NUM_ISSUES       = 2000;
    localparam int COMPLETE_CREDITS = 2;     // DUT default
    localparam int TAGS             = 1 << TAG_WIDTH;
    localparam int QUIET_CYCLES     = 5;
    localparam int CREDIT_WINDOW    = 240;
    localparam int CREDIT_HOLD      = 80;    // Withheld at the start of each window
    localparam int TIMEOUT_CYCLES   = NUM_ISSUES * 20;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;

    logic      clock;
    logic      reset;
    logic      issue_valid;
    fu_kind_t  issue_fu;
    alu_func_t issue_func;
    opa_sel_t  opa_select;
    opb_sel_t  opb_select;
    inst_t     inst;
    xlen_t     pc;
    xlen_t     rs1_value;
    xlen_t     rs2_value;
    tag_t      issue_tag;
    logic      complete_credit;
    fu_vec_t   fu_free;
    logic      complete_valid;
    fu_kind_t  complete_fu;
    tag_t      complete_tag;
    xlen_t     complete_result;
    logic      complete_take;

    // Scoreboard filed by tag
    bit       pending [TAGS];
    fu_kind_t exp_fu [TAGS];
    xlen_t    exp_result [TAGS];
    logic     exp_take [TAGS];

    fu_vec_t held;       // Issue credits in hand
    fu_vec_t last_free;
    tag_t    next_tag;
    int      issued, outstanding, owed, credits_returned, valid_total, cycle_count;
    int      free_count [3];
    int      done_count [3];

    exec_clock_gen u_clock_gen (.clock, .reset);

    exec_stage u_exec_stage (
        .clock, .reset, .issue_valid, .issue_fu, .issue_func, .opa_select, .opb_select,
        .inst, .pc, .rs1_value, .rs2_value, .issue_tag, .complete_credit, .fu_free,
        .complete_valid, .complete_fu, .complete_tag, .complete_result, .complete_take
    );

    bind exec_stage exec_stage_asserts #(.COMPLETE_CREDITS(COMPLETE_CREDITS)) u_asserts (
        .clock(clock), .reset(reset), .issue_valid(issue_valid), .issue_fu(issue_fu),
        .fu_free(fu_free), .complete_valid(complete_valid), .complete_credit(complete_credit)
    );

    ////////////////////
    // Reference model

    function automatic xlen_t sign_extend(input xlen_t value, input int width);
        xlen_t shifted;
        shifted = value << (XLEN - width);
        return xlen_t'($signed(shifted) >>> (XLEN - width));
    endfunction

    function automatic xlen_t operand_a(input opa_sel_t sel, input xlen_t pc_v, input xlen_t rs1);
        case (sel)
            RS1:     return rs1;
            NPC:     return pc_v + 32'd4;
            PC:      return pc_v;
            default: return '0;
        endcase
    endfunction

    function automatic xlen_t operand_b(input opb_sel_t sel, input inst_t w, input xlen_t rs2);
        case (sel)
            RS2:     return rs2;
            I_IMM:   return sign_extend(xlen_t'(w[31:20]), 12);
            S_IMM:   return sign_extend(xlen_t'({w[31:25], w[11:7]}), 12);
            B_IMM:   return sign_extend(xlen_t'({w[31], w[7], w[30:25], w[11:8], 1'b0}), 13);
            U_IMM:   return {w[31:12], 12'h000};
            J_IMM:   return sign_extend(xlen_t'({w[31], w[19:12], w[20], w[30:21], 1'b0}), 21);
            default: return '0;
        endcase
    endfunction

    function automatic xlen_t alu_expect(input alu_func_t func, input xlen_t a, input xlen_t b);
        xlen_t sh;
        sh = b % XLEN;  // Shift amount wraps at the word width
        case (func)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return xlen_t'($signed(a) >>> sh);
            default:  return '0;
        endcase
    endfunction

    function automatic xlen_t mult_expect(input alu_func_t func, input xlen_t a, input xlen_t b);
        longint a_wide;
        longint b_wide;
        longint prod;
        a_wide = (func == ALU_MULHU) ? longint'(a) : longint'($signed(a));
        b_wide = (func == ALU_MULHU || func == ALU_MULHSU) ? longint'(b) : longint'($signed(b));
        prod   = a_wide * b_wide;  // Low 64 bits are exact either way
        return (func == ALU_MUL) ? prod[31:0] : prod[63:32];
    endfunction

    function automatic logic branch_taken(input inst_t w, input xlen_t rs1, input xlen_t rs2);
        if (w[6:0] == OPCODE_JAL || w[6:0] == OPCODE_JALR) begin
            return 1'b1;
        end
        case (w[14:12])
            F3_BEQ:  return rs1 == rs2;
            F3_BNE:  return rs1 != rs2;
            F3_BLT:  return $signed(rs1) < $signed(rs2);
            F3_BGE:  return $signed(rs1) >= $signed(rs2);
            F3_BLTU: return rs1 < rs2;
            F3_BGEU: return rs1 >= rs2;
            default: return 1'b0;
        endcase
    endfunction

    function automatic xlen_t branch_dest(input inst_t w, input xlen_t a, input xlen_t b);
        xlen_t sum;
        sum = a + b;
        if (w[6:0] == OPCODE_JALR) begin
            sum[0] = 1'b0;
        end
        return sum;
    endfunction

    function automatic xlen_t random_operand();
        case ($urandom_range(0, 3))
            0:       return xlen_t'($urandom_range(0, 40));              // Small values
            1:       return 32'h8000_0000 ^ xlen_t'($urandom_range(0, 3));
            default: return $urandom();
        endcase
    endfunction

    ////////////////////
    // Error reporting

    task automatic show_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        $display("Mismatch at %0t ns: %s got %h, expected %h", $time, name, got, expected);
        $display("CHECKS FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic abort_run(input string what);
        $display("Error at %0t ns: %s", $time, what);
        $display("CHECKS FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    ////////////////////
    // Stimulus and scoreboard

    task automatic drive_issue(input fu_kind_t fu);
        alu_func_t func_v;
        opa_sel_t  a_sel;
        opb_sel_t  b_sel;
        inst_t     word;
        xlen_t     pc_v;
        xlen_t     rs1_v;
        xlen_t     rs2_v;
        xlen_t     a_v;
        xlen_t     b_v;
        int        t;

        word   = $urandom();
        pc_v   = $urandom() & 32'hFFFF_FFFC;
        rs1_v  = random_operand();
        rs2_v  = ($urandom_range(0, 3) == 0) ? rs1_v : random_operand();  // Equal for BEQ
        a_sel  = opa_sel_t'(2'($urandom_range(0, 3)));
        b_sel  = opb_sel_t'(3'($urandom_range(0, 7)));  // 6 and 7 select zero
        func_v = ALU_ADD;
        case (fu)
            FU_ALU:  func_v = alu_func_t'(4'($urandom_range(0, 9)));
            FU_MULT: func_v = alu_func_t'(4'($urandom_range(10, 13)));
            default: begin
                case ($urandom_range(0, 3))
                    0:       word[6:0] = OPCODE_JAL;
                    1:       word[6:0] = OPCODE_JALR;
                    default: word[6:0] = OPCODE_BRANCH;
                endcase
            end
        endcase
        a_v = operand_a(a_sel, pc_v, rs1_v);
        b_v = operand_b(b_sel, word, rs2_v);

        while (pending[next_tag]) begin
            next_tag = next_tag + 1'b1;
        end
        t = int'(next_tag);
        pending[t]  = 1'b1;
        exp_fu[t]   = fu;
        exp_take[t] = (fu == FU_BRANCH) && branch_taken(word, rs1_v, rs2_v);
        case (fu)
            FU_ALU:  exp_result[t] = alu_expect(func_v, a_v, b_v);
            FU_MULT: exp_result[t] = mult_expect(func_v, a_v, b_v);
            default: exp_result[t] = branch_dest(word, a_v, b_v);
        endcase

        issue_valid = 1'b1;
        issue_fu    = fu;
        issue_func  = func_v;
        opa_select  = a_sel;
        opb_select  = b_sel;
        inst        = word;
        pc          = pc_v;
        rs1_value   = rs1_v;
        rs2_value   = rs2_v;
        issue_tag   = next_tag;
        next_tag    = next_tag + 1'b1;
        held[fu]    = 1'b0;
        issued++;
        outstanding++;
    endtask

    // Sampled at the falling edge, after any issue for this cycle is decided
    task automatic observe_outputs();
        int t;
        if (complete_valid) begin
            t = int'(complete_tag);
            valid_total++;
            assert (pending[t]) else abort_run("complete_tag matches no outstanding issue");
            assert (complete_fu == exp_fu[t])
                else show_mismatch("complete_fu", 32'(complete_fu), 32'(exp_fu[t]));
            assert (complete_result == exp_result[t])
                else show_mismatch("complete_result", complete_result, exp_result[t]);
            assert (complete_take == exp_take[t])
                else show_mismatch("complete_take", 32'(complete_take), 32'(exp_take[t]));
            assert (last_free[complete_fu])
                else abort_run("completion without a fu_free pulse the cycle before");
            assert (valid_total <= COMPLETE_CREDITS + credits_returned)
                else abort_run("more completions than completion credits handed out");
            pending[t] = 1'b0;
            outstanding--;
            owed++;
            done_count[complete_fu]++;
        end
        for (int k = 0; k < 3; k++) begin
            if (fu_free[k]) begin
                free_count[k]++;
                held[k] = 1'b1;
            end
        end
        last_free = fu_free;
    endtask

    task automatic step_cycle(input bit allow_issue);
        int first;
        bit picked;
        @(negedge clock);
        cycle_count++;
        issue_valid = 1'b0;
        picked      = 1'b0;
        if (allow_issue && issued < NUM_ISSUES && $urandom_range(0, 3) != 0) begin
            first = int'($urandom_range(0, 2));
            for (int n = 0; n < 3; n++) begin
                if (!picked && held[(first + n) % 3]) begin
                    drive_issue(fu_kind_t'(2'((first + n) % 3)));
                    picked = 1'b1;
                end
            end
        end
        complete_credit = 1'b0;
        if ((cycle_count % CREDIT_WINDOW) >= CREDIT_HOLD && owed > 0
                && $urandom_range(0, 1) == 1) begin
            complete_credit = 1'b1;
            owed--;
            credits_returned++;
        end
        observe_outputs();
    endtask

    ////////////////////
    // Test sequence

    initial begin
        void'($urandom(SEED));
        issue_valid     = 1'b0;
        issue_fu        = FU_ALU;
        issue_func      = ALU_ADD;
        opa_select      = RS1;
        opb_select      = RS2;
        inst            = '0;
        pc              = '0;
        rs1_value       = '0;
        rs2_value       = '0;
        issue_tag       = '0;
        complete_credit = 1'b0;
        held            = 3'b111;
        last_free       = '0;
        next_tag        = '0;
        for (int i = 0; i < TAGS; i++) begin
            pending[i] = 1'b0;
        end
        for (int k = 0; k < 3; k++) begin
            free_count[k] = 0;
            done_count[k] = 0;
        end

        @(negedge clock);
        while (reset) begin
            @(negedge clock);
        end

        // Bus stays quiet until the first issue
        repeat (QUIET_CYCLES) begin
            @(negedge clock);
            assert (!complete_valid && fu_free == '0)
                else abort_run("completion bus active before any issue");
        end

        // Lone ALU op reaches the bus two cycles after issue
        @(negedge clock);
        drive_issue(FU_ALU);
        observe_outputs();
        @(negedge clock);
        issue_valid = 1'b0;
        assert (!complete_valid) else abort_run("ALU result on the bus one cycle after issue");
        observe_outputs();
        @(negedge clock);
        assert (complete_valid) else abort_run("ALU result missing two cycles after issue");
        observe_outputs();

        while (issued < NUM_ISSUES) begin
            step_cycle(1'b1);
        end
        while (outstanding != 0 || held != 3'b111) begin
            step_cycle(1'b0);  // Drain
        end

        for (int k = 0; k < 3; k++) begin
            assert (free_count[k] == done_count[k])
                else show_mismatch($sformatf("fu_free[%0d] pulse count", k),
                                   free_count[k], done_count[k]);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clock);
        $display("Timeout after %0d cycles with %0d issued and %0d outstanding",
                 TIMEOUT_CYCLES, issued, outstanding);
        $display("CHECKS FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire
